// ==== sim/datapath_input.txt ====
# word(hex) gap rd we data(hex) cause
# one fetched instruction per line, gap = idle fetch cycles before it
00500093 0 1 1 0000000000000005 0
00700113 0 2 1 0000000000000007 0
002081B3 1 3 1 000000000000000C 0
40118233 0 4 1 0000000000000007 0
0041F2B3 0 5 1 0000000000000004 0
0012E333 0 6 1 0000000000000005 0
002343B3 0 7 1 0000000000000002 0
12345437 2 8 1 0000000012345000 0
800004B7 0 9 1 FFFFFFFF80000000 0
FFF40513 0 10 1 0000000012344FFF 0
00900013 0 0 0 0000000000000000 0
000005B3 0 11 1 0000000000000000 0
34009673 0 12 1 A5A5000000000340 0
340126F3 0 13 1 0000000000000005 0
3400B773 1 14 1 0000000000000007 0
341027F3 0 15 1 A5A5000000000341 0
3421D873 0 16 1 A5A5000000000342 0
342468F3 0 17 1 0000000000000003 0
3420F973 0 18 1 000000000000000B 0
343079F3 0 19 1 A5A5000000000343 0
34169A73 0 20 1 A5A5000000000341 0
00000073 0 0 0 0000000000000000 11
0000038B 0 7 0 0000000000000000 2
00038AB3 0 21 1 0000000000000002 0
001A8B13 3 22 1 0000000000000003 0

// ==== filelist.f ====
common/drac_lite_pkg.sv
logic/stage_register.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/regfile.sv
logic/exe_stage.sv
logic/wb_csr_ctrl.sv
logic/datapath.sv
sim/datapath_checker.sv
sim/tb_datapath.sv

// ==== sim/tb_datapath.sv ====
// Datapath testbench

`timescale 1ns/1ps

module tb_datapath;

    import drac_lite_pkg::*;

    localparam bus64_t RESET_PC = 64'h1000;
    localparam int     MAX_LINES = 64;

    logic             clk_i;
    logic             rstn_i;
    resp_icache_cpu_t icache_resp;
    resp_csr_cpu_t    csr_resp;
    req_cpu_icache_t  icache_req;
    req_cpu_csr_t     csr_req;
    commit_t          commit;

    // expected program with one entry per input line
    instr_word_t in_word  [0:MAX_LINES-1];
    int          in_gap   [0:MAX_LINES-1];
    reg_addr_t   in_rd    [0:MAX_LINES-1];
    logic        in_we    [0:MAX_LINES-1];
    bus64_t      in_data  [0:MAX_LINES-1];
    xcpt_cause_t in_cause [0:MAX_LINES-1];
    int          n_lines = 0;
    int          commits_done = 0;
    int          pending_q [$];
    bus64_t      shadow [0:31];
    bus64_t      csr_mem [0:3];

    datapath #(
        .RESET_PC(RESET_PC)
    ) u_datapath (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .resp_icache_cpu_i(icache_resp),
        .resp_csr_cpu_i   (csr_resp),
        .req_cpu_icache_o (icache_req),
        .req_cpu_csr_o    (csr_req),
        .commit_o         (commit)
    );

    bind datapath datapath_checker u_checker (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .commit_i (commit_o),
        .req_csr_i(req_cpu_csr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // csr model for 0x340 to 0x343
    // the old value returns combinationally
    assign csr_resp.csr_rw_rdata = csr_mem[csr_req.csr_rw_addr[1:0]];

    initial begin
        for (int i = 0; i < 4; i++) begin
            csr_mem[i] = 64'hA5A5_0000_0000_0000 | (64'h340 + i);
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
    end

    always @(posedge clk_i) begin
        case (csr_req.csr_rw_cmd)
            CSR_CMD_WRITE: csr_mem[csr_req.csr_rw_addr[1:0]] <= csr_req.csr_rw_data;
            CSR_CMD_SET:   csr_mem[csr_req.csr_rw_addr[1:0]] <=
                               csr_mem[csr_req.csr_rw_addr[1:0]] | csr_req.csr_rw_data;
            CSR_CMD_CLEAR: csr_mem[csr_req.csr_rw_addr[1:0]] <=
                               csr_mem[csr_req.csr_rw_addr[1:0]] & ~csr_req.csr_rw_data;
            default: ;
        endcase
    end

    task automatic report_error(input string what, input bus64_t got, input bus64_t exp);
        $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_fetch(input req_cpu_icache_t act, input req_cpu_icache_t exp);
        if (act.valid !== exp.valid)
            report_error("fetch valid", act.valid, exp.valid);
        if (act.pc !== exp.pc)
            report_error("fetch pc", act.pc, exp.pc);
    endtask

    task automatic check_commit(input commit_t act, input commit_t exp);
        if (act.pc !== exp.pc) report_error("commit pc", act.pc, exp.pc);
        if (act.reg_we !== exp.reg_we) report_error("commit reg_we", act.reg_we, exp.reg_we);
        if (act.rd !== exp.rd) report_error("commit rd", act.rd, exp.rd);
        if (exp.reg_we && (act.data !== exp.data)) report_error("commit data", act.data, exp.data);
    endtask

    task automatic check_csr(input req_cpu_csr_t act, input req_cpu_csr_t exp);
        if (act.csr_rw_cmd !== exp.csr_rw_cmd)
            report_error("csr cmd", act.csr_rw_cmd, exp.csr_rw_cmd);
        if (act.csr_rw_addr !== exp.csr_rw_addr)
            report_error("csr addr", act.csr_rw_addr, exp.csr_rw_addr);
        if (act.csr_rw_data !== exp.csr_rw_data)
            report_error("csr data", act.csr_rw_data, exp.csr_rw_data);
        if (act.csr_retire !== exp.csr_retire)
            report_error("csr retire", act.csr_retire, exp.csr_retire);
        if (act.csr_exception !== exp.csr_exception)
            report_error("csr exception", act.csr_exception, exp.csr_exception);
        if (exp.csr_exception && (act.csr_xcpt_cause !== exp.csr_xcpt_cause))
            report_error("csr cause", act.csr_xcpt_cause, exp.csr_xcpt_cause);
        if (exp.csr_exception && (act.csr_pc !== exp.csr_pc))
            report_error("csr pc", act.csr_pc, exp.csr_pc);
    endtask

    // csr request built from the instruction word and the shadow registers
    function automatic req_cpu_csr_t expected_csr(input int idx);
        req_cpu_csr_t exp;
        logic [2:0]   f3;
        reg_addr_t    rs1;
        exp = '0;
        f3  = in_word[idx][14:12];
        rs1 = in_word[idx][19:15];
        if ((in_word[idx][6:0] == 7'h73) && (f3 != 3'b000)) begin
            exp.csr_rw_addr = in_word[idx][31:20];
            exp.csr_rw_data = f3[2] ? {59'b0, rs1} : shadow[rs1];
            case (f3[1:0])
                2'b01:   exp.csr_rw_cmd = CSR_CMD_WRITE;
                2'b10:   exp.csr_rw_cmd = (rs1 == '0) ? CSR_CMD_READ : CSR_CMD_SET;
                default: exp.csr_rw_cmd = (rs1 == '0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
            endcase
        end else if (in_cause[idx] == CAUSE_ECALL) begin
            exp.csr_rw_cmd = CSR_CMD_SYS;
        end
        exp.csr_exception  = (in_cause[idx] != '0);
        exp.csr_retire     = !exp.csr_exception;
        exp.csr_xcpt_cause = in_cause[idx];
        exp.csr_pc         = RESET_PC + 64'(4 * idx);
        return exp;
    endfunction

    always @(negedge clk_i) begin
        int      idx;
        commit_t exp;
        if (rstn_i && commit.valid) begin
            if (pending_q.size() == 0) begin
                $display("Unexpected commit at pc %h with no instruction pending", commit.pc);
                $display(">>> FAIL");
                $fatal(1);
            end
            idx        = pending_q.pop_front();
            exp.valid  = 1'b1;
            exp.pc     = RESET_PC + 64'(4 * idx);
            exp.reg_we = in_we[idx];
            exp.rd     = in_rd[idx];
            exp.data   = in_data[idx];
            check_commit(commit, exp);
            check_csr(csr_req, expected_csr(idx));
            if (in_we[idx]) begin
                shadow[in_rd[idx]] = in_data[idx];
            end
            commits_done++;
        end
    end

    // 40 cycles per line plus reset
    initial begin
        wait (n_lines > 0);
        #((n_lines * 40 + 10) * 20);
        $display("Timeout: the pipeline stopped committing instructions");
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        wait (u_datapath.u_checker.fail_count != 0);
        $display("A datapath checker assertion failed");
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        int    fd;
        int    cnt;
        string line;
        logic [31:0] w;
        int    g;
        int    r;
        int    we;
        logic [63:0] d;
        int    c;
        req_cpu_icache_t exp_req;
        rstn_i      = 1'b0;
        icache_resp = '0;
        fd = $fopen("sim/datapath_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file sim/datapath_input.txt");
            $display(">>> FAIL");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %d %d %d %h %d", w, g, r, we, d, c);
            if ((cnt == 6) && (line.substr(0, 0) != "#")) begin
                in_word[n_lines]  = w;
                in_gap[n_lines]   = g;
                in_rd[n_lines]    = r[4:0];
                in_we[n_lines]    = we[0];
                in_data[n_lines]  = d;
                in_cause[n_lines] = c[7:0];
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("The input file sim/datapath_input.txt holds no instructions");
            $display(">>> FAIL");
            $fatal(1);
        end

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // the fetch pc only moves on for a fetched word
        exp_req.valid = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            exp_req.pc = RESET_PC + 64'(4 * i);
            repeat (in_gap[i]) begin
                @(negedge clk_i);
                check_fetch(icache_req, exp_req);
                icache_resp = '0;
            end
            @(negedge clk_i);
            check_fetch(icache_req, exp_req);
            icache_resp.valid = 1'b1;
            icache_resp.instr = in_word[i];
            pending_q.push_back(i);
        end
        @(negedge clk_i);
        exp_req.pc = RESET_PC + 64'(4 * n_lines);
        check_fetch(icache_req, exp_req);
        icache_resp = '0;

        wait (commits_done == n_lines);
        repeat (2) @(negedge clk_i);
        if (u_datapath.u_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/datapath_checker.sv ====
// Datapath port assertions

`timescale 1ns/1ps

module datapath_checker (
    input logic                         clk_i,
    input logic                         rstn_i,
    input drac_lite_pkg::commit_t       commit_i,
    input drac_lite_pkg::req_cpu_csr_t  req_csr_i
);

    import drac_lite_pkg::*;

    // number of assertion failures so far
    int unsigned fail_count = 0;

    // nothing commits or traps while reset is held
    assert property (@(posedge clk_i)
        !rstn_i |-> (!commit_i.valid && !req_csr_i.csr_exception))
    else begin
        fail_count++;
        $error("commit or exception active during reset");
    end

    // an instruction either retires or traps
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_csr_i.csr_retire && req_csr_i.csr_exception))
    else begin
        fail_count++;
        $error("retire and exception high together");
    end

    // csr commands only come with an instruction in write-back
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !commit_i.valid |-> (req_csr_i.csr_rw_cmd == CSR_CMD_NOPE))
    else begin
        fail_count++;
        $error("csr command without a committing instruction");
    end

endmodule

// ==== logic/datapath.sv ====
// Five-stage integer datapath

`timescale 1ns/1ps

module datapath #(
    parameter drac_lite_pkg::bus64_t RESET_PC = 64'h1000
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  drac_lite_pkg::resp_icache_cpu_t resp_icache_cpu_i,
    input  drac_lite_pkg::resp_csr_cpu_t    resp_csr_cpu_i,
    output drac_lite_pkg::req_cpu_icache_t  req_cpu_icache_o,
    output drac_lite_pkg::req_cpu_csr_t     req_cpu_csr_o,
    output drac_lite_pkg::commit_t          commit_o
);

    import drac_lite_pkg::*;

    // stage order is if, id, rr, exe and wb
    if_id_stage_t  stage_if_id_d;
    if_id_stage_t  stage_if_id_q;
    instr_entry_t  stage_id_rr_d;
    instr_entry_t  stage_id_rr_q;
    rr_exe_instr_t stage_rr_exe_d;
    rr_exe_instr_t stage_rr_exe_q;
    exe_wb_instr_t stage_exe_wb_d;
    exe_wb_instr_t stage_exe_wb_q;

    bus64_t        rf_rdata1;
    bus64_t        rf_rdata2;
    logic          rf_we;
    bus64_t        rf_wdata;
    wb_exe_instr_t wb_fwd;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .resp_icache_i(resp_icache_cpu_i),
        .req_icache_o (req_cpu_icache_o),
        .fetch_o      (stage_if_id_d)
    );

    // no data hazards stall, so every register loads each cycle
    stage_register #(.WIDTH($bits(if_id_stage_t))) u_reg_if_id (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .flush_i(1'b0),
        .load_i (1'b1),
        .data_i (stage_if_id_d),
        .data_o (stage_if_id_q)
    );

    decoder u_decoder (
        .decode_i      (stage_if_id_q),
        .decode_instr_o(stage_id_rr_d)
    );

    stage_register #(.WIDTH($bits(instr_entry_t))) u_reg_id_rr (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .flush_i(1'b0),
        .load_i (1'b1),
        .data_i (stage_id_rr_d),
        .data_o (stage_id_rr_q)
    );

    // write port driven from write-back
    regfile u_regfile (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .write_enable_i(rf_we),
        .write_addr_i  (stage_exe_wb_q.rd),
        .read_addr1_i  (stage_id_rr_q.rs1),
        .read_addr2_i  (stage_id_rr_q.rs2),
        .write_data_i  (rf_wdata),
        .read_data1_o  (rf_rdata1),
        .read_data2_o  (rf_rdata2)
    );

    assign stage_rr_exe_d = '{instr: stage_id_rr_q, data_rs1: rf_rdata1, data_rs2: rf_rdata2};

    stage_register #(.WIDTH($bits(rr_exe_instr_t))) u_reg_rr_exe (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .flush_i(1'b0),
        .load_i (1'b1),
        .data_i (stage_rr_exe_d),
        .data_o (stage_rr_exe_q)
    );

    exe_stage u_exe (
        .from_rr_i(stage_rr_exe_q),
        .from_wb_i(wb_fwd),
        .to_wb_o  (stage_exe_wb_d)
    );

    stage_register #(.WIDTH($bits(exe_wb_instr_t))) u_reg_exe_wb (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .flush_i(1'b0),
        .load_i (1'b1),
        .data_i (stage_exe_wb_d),
        .data_o (stage_exe_wb_q)
    );

    wb_csr_ctrl u_wb (
        .wb_i      (stage_exe_wb_q),
        .resp_csr_i(resp_csr_cpu_i),
        .req_csr_o (req_cpu_csr_o),
        .rf_we_o   (rf_we),
        .rf_wdata_o(rf_wdata),
        .fwd_o     (wb_fwd),
        .commit_o  (commit_o)
    );

endmodule

// ==== logic/wb_csr_ctrl.sv ====
// Write-back and CSR control

`timescale 1ns/1ps

module wb_csr_ctrl (
    input  drac_lite_pkg::exe_wb_instr_t wb_i,
    input  drac_lite_pkg::resp_csr_cpu_t resp_csr_i,
    output drac_lite_pkg::req_cpu_csr_t  req_csr_o,
    output logic                         rf_we_o,
    output drac_lite_pkg::bus64_t        rf_wdata_o,
    output drac_lite_pkg::wb_exe_instr_t fwd_o,
    output drac_lite_pkg::commit_t       commit_o
);

    import drac_lite_pkg::*;

    csr_cmd_t cmd;
    bus64_t   csr_wdata;
    bus64_t   zimm;
    logic     rs1_zero;
    logic     csr_rd_sel;

    // immediate forms use the rs1 field as a 5-bit value
    assign zimm     = {{(XLEN-REG_ADDR_W){1'b0}}, wb_i.rs1};
    assign rs1_zero = (wb_i.rs1 == '0);

    always_comb begin
        cmd       = CSR_CMD_NOPE;
        csr_wdata = '0;
        if (wb_i.valid) begin
            case (wb_i.instr_type)
                CSRRW: begin
                    cmd       = CSR_CMD_WRITE;
                    csr_wdata = wb_i.result;
                end
                CSRRS: begin
                    cmd       = rs1_zero ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_wdata = wb_i.result;
                end
                CSRRC: begin
                    cmd       = rs1_zero ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_wdata = wb_i.result;
                end
                CSRRWI: begin
                    cmd       = CSR_CMD_WRITE;
                    csr_wdata = zimm;
                end
                CSRRSI: begin
                    cmd       = rs1_zero ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_wdata = zimm;
                end
                CSRRCI: begin
                    cmd       = rs1_zero ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_wdata = zimm;
                end
                ECALL:  cmd = CSR_CMD_SYS;
                default: cmd = CSR_CMD_NOPE;
            endcase
        end
    end

    // rd of a csr access gets the old csr value
    assign csr_rd_sel = (cmd != CSR_CMD_NOPE) && (cmd != CSR_CMD_SYS);

    assign req_csr_o.csr_rw_addr    = (cmd != CSR_CMD_NOPE) ? wb_i.csr_addr : '0;
    assign req_csr_o.csr_rw_cmd     = cmd;
    assign req_csr_o.csr_rw_data    = csr_wdata;
    assign req_csr_o.csr_retire     = wb_i.valid && !wb_i.ex_valid;
    assign req_csr_o.csr_exception  = wb_i.valid && wb_i.ex_valid;
    assign req_csr_o.csr_xcpt_cause = wb_i.ex_cause;
    assign req_csr_o.csr_pc         = wb_i.pc;

    // excepting instructions never write back
    assign rf_we_o    = wb_i.valid && wb_i.regfile_we && !wb_i.ex_valid;
    assign rf_wdata_o = csr_rd_sel ? resp_csr_i.csr_rw_rdata : wb_i.result;

    assign fwd_o.valid = rf_we_o;
    assign fwd_o.rd    = wb_i.rd;
    assign fwd_o.data  = rf_wdata_o;

    assign commit_o.valid  = wb_i.valid;
    assign commit_o.pc     = wb_i.pc;
    assign commit_o.reg_we = rf_we_o;
    assign commit_o.rd     = wb_i.rd;
    assign commit_o.data   = rf_wdata_o;

endmodule

// ==== logic/exe_stage.sv ====
// Execute stage

`timescale 1ns/1ps

module exe_stage (
    input  drac_lite_pkg::rr_exe_instr_t from_rr_i,
    input  drac_lite_pkg::wb_exe_instr_t from_wb_i,
    output drac_lite_pkg::exe_wb_instr_t to_wb_o
);

    import drac_lite_pkg::*;

    instr_entry_t instr;
    bus64_t       op_a;
    bus64_t       op_b;
    bus64_t       result;

    assign instr = from_rr_i.instr;

    // bypass from write-back
    // fwd valid includes the write enable
    function automatic bus64_t bypass(reg_addr_t addr, bus64_t rf_data);
        bus64_t data;
        if (from_wb_i.valid && (from_wb_i.rd == addr) && (addr != '0)) begin
            data = from_wb_i.data;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    assign op_a = bypass(instr.rs1, from_rr_i.data_rs1);
    assign op_b = bypass(instr.rs2, from_rr_i.data_rs2);

    always_comb begin
        case (instr.instr_type)
            ADD:   result = op_a + op_b;
            SUB:   result = op_a - op_b;
            AND:   result = op_a & op_b;
            OR:    result = op_a | op_b;
            XOR:   result = op_a ^ op_b;
            ADDI:  result = op_a + instr.imm;
            LUI:   result = instr.imm;
            // register forms carry the csr write data
            CSRRW, CSRRS, CSRRC: result = op_a;
            default: result = '0;
        endcase
    end

    assign to_wb_o.valid      = instr.valid;
    assign to_wb_o.pc         = instr.pc;
    assign to_wb_o.rd         = instr.rd;
    assign to_wb_o.rs1        = instr.rs1;
    assign to_wb_o.regfile_we = instr.regfile_we;
    assign to_wb_o.instr_type = instr.instr_type;
    assign to_wb_o.result     = result;
    assign to_wb_o.csr_addr   = instr.csr_addr;
    assign to_wb_o.ex_valid   = instr.ex_valid;
    assign to_wb_o.ex_cause   = instr.ex_cause;

endmodule

// ==== logic/regfile.sv ====
// Integer register file

`timescale 1ns/1ps

module regfile (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     write_enable_i,
    input  drac_lite_pkg::reg_addr_t write_addr_i,
    input  drac_lite_pkg::reg_addr_t read_addr1_i,
    input  drac_lite_pkg::reg_addr_t read_addr2_i,
    input  drac_lite_pkg::bus64_t    write_data_i,
    output drac_lite_pkg::bus64_t    read_data1_o,
    output drac_lite_pkg::bus64_t    read_data2_o
);

    import drac_lite_pkg::*;

    // x0 has no storage
    bus64_t regs_q [1:31];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_enable_i && (write_addr_i != '0)) begin
            regs_q[write_addr_i] <= write_data_i;
        end
    end

    // write-through read port
    function automatic bus64_t read_port(reg_addr_t addr);
        bus64_t data;
        if (addr == '0) begin
            data = '0;
        end else if (write_enable_i && (write_addr_i == addr)) begin
            data = write_data_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    assign read_data1_o = read_port(read_addr1_i);
    assign read_data2_o = read_port(read_addr2_i);

endmodule

// ==== logic/decoder.sv ====
// Instruction decoder

`timescale 1ns/1ps

module decoder (
    input  drac_lite_pkg::if_id_stage_t decode_i,
    output drac_lite_pkg::instr_entry_t decode_instr_o
);

    import drac_lite_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd;
    instr_type_t itype;
    logic        is_xcpt;
    bus64_t      imm_i;
    bus64_t      imm_u;

    assign opcode = decode_i.instr[6:0];
    assign funct3 = decode_i.instr[14:12];
    assign funct7 = decode_i.instr[31:25];
    assign rd     = decode_i.instr[11:7];

    assign imm_i = {{52{decode_i.instr[31]}}, decode_i.instr[31:20]};
    // RV64 lui sign-extends the 32-bit value
    assign imm_u = {{32{decode_i.instr[31]}}, decode_i.instr[31:12], 12'b0};

    always_comb begin
        itype = ILLEGAL;
        case (opcode)
            OP_REG: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: itype = ADD;
                    {7'b0100000, 3'b000}: itype = SUB;
                    {7'b0000000, 3'b111}: itype = AND;
                    {7'b0000000, 3'b110}: itype = OR;
                    {7'b0000000, 3'b100}: itype = XOR;
                    default:              itype = ILLEGAL;
                endcase
            end
            OP_IMM: begin
                if (funct3 == 3'b000) begin
                    itype = ADDI;
                end
            end
            OP_LUI: itype = LUI;
            OP_SYSTEM: begin
                case (funct3)
                    // only the exact ecall word, ebreak and trap returns are out
                    3'b000:  itype = (decode_i.instr[31:7] == '0) ? ECALL : ILLEGAL;
                    3'b001:  itype = CSRRW;
                    3'b010:  itype = CSRRS;
                    3'b011:  itype = CSRRC;
                    3'b101:  itype = CSRRWI;
                    3'b110:  itype = CSRRSI;
                    3'b111:  itype = CSRRCI;
                    default: itype = ILLEGAL;
                endcase
            end
            default: itype = ILLEGAL;
        endcase
    end

    assign is_xcpt = (itype == ECALL) || (itype == ILLEGAL);

    assign decode_instr_o.valid      = decode_i.valid;
    assign decode_instr_o.pc         = decode_i.pc;
    assign decode_instr_o.rs1        = decode_i.instr[19:15];
    assign decode_instr_o.rs2        = decode_i.instr[24:20];
    assign decode_instr_o.rd         = rd;
    // x0 is never written
    assign decode_instr_o.regfile_we = decode_i.valid && !is_xcpt && (rd != '0);
    assign decode_instr_o.instr_type = itype;
    assign decode_instr_o.imm        = (itype == LUI) ? imm_u : imm_i;
    assign decode_instr_o.csr_addr   = decode_i.instr[31:20];
    assign decode_instr_o.ex_valid   = decode_i.valid && is_xcpt;
    assign decode_instr_o.ex_cause   = (itype == ECALL) ? CAUSE_ECALL : CAUSE_ILLEGAL;

endmodule

// ==== logic/fetch_stage.sv ====
// Instruction fetch

`timescale 1ns/1ps

module fetch_stage #(
    parameter drac_lite_pkg::bus64_t RESET_PC = 64'h1000
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  drac_lite_pkg::resp_icache_cpu_t resp_icache_i,
    output drac_lite_pkg::req_cpu_icache_t  req_icache_o,
    output drac_lite_pkg::if_id_stage_t     fetch_o
);

    import drac_lite_pkg::*;

    bus64_t pc_q;

    // pc only moves on when the icache answered
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else if (resp_icache_i.valid) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    // request is always outstanding
    assign req_icache_o.valid = 1'b1;
    assign req_icache_o.pc    = pc_q;

    // no response means a bubble downstream
    assign fetch_o.valid = resp_icache_i.valid;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = resp_icache_i.instr;

endmodule

// ==== logic/stage_register.sv ====
// Pipeline stage register

`timescale 1ns/1ps

module stage_register #(
    parameter int WIDTH = 1
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             flush_i,
    input  logic             load_i,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    // flush turns the stage into a bubble
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            data_o <= '0;
        end else if (flush_i) begin
            data_o <= '0;
        end else if (load_i) begin
            data_o <= data_i;
        end
    end

endmodule

// ==== common/drac_lite_pkg.sv ====
// Datapath shared definitions

package drac_lite_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       bus64_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ILEN-1:0]       instr_word_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [7:0]            xcpt_cause_t;

    // mcause codes
    localparam xcpt_cause_t CAUSE_ILLEGAL = 8'd2;
    localparam xcpt_cause_t CAUSE_ECALL   = 8'd11;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, ADDI, LUI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, ILLEGAL
    } instr_type_t;

    // same encoding as the csr file commands
    typedef enum logic [2:0] {
        CSR_CMD_NOPE  = 3'b000,
        CSR_CMD_WRITE = 3'b001,
        CSR_CMD_SET   = 3'b010,
        CSR_CMD_CLEAR = 3'b011,
        CSR_CMD_SYS   = 3'b100,
        CSR_CMD_READ  = 3'b101
    } csr_cmd_t;

    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        instr_word_t instr;
    } if_id_stage_t;

    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic        regfile_we;
        instr_type_t instr_type;
        bus64_t      imm;
        csr_addr_t   csr_addr;
        logic        ex_valid;
        xcpt_cause_t ex_cause;
    } instr_entry_t;

    typedef struct packed {
        instr_entry_t instr;
        bus64_t       data_rs1;
        bus64_t       data_rs2;
    } rr_exe_instr_t;

    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic        regfile_we;
        instr_type_t instr_type;
        bus64_t      result;
        csr_addr_t   csr_addr;
        logic        ex_valid;
        xcpt_cause_t ex_cause;
    } exe_wb_instr_t;

    // write-back bypass towards execute
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus64_t    data;
    } wb_exe_instr_t;

    typedef struct packed {
        logic   valid;
        bus64_t pc;
    } req_cpu_icache_t;

    typedef struct packed {
        logic        valid;
        instr_word_t instr;
    } resp_icache_cpu_t;

    typedef struct packed {
        csr_addr_t   csr_rw_addr;
        csr_cmd_t    csr_rw_cmd;
        bus64_t      csr_rw_data;
        logic        csr_retire;
        logic        csr_exception;
        xcpt_cause_t csr_xcpt_cause;
        bus64_t      csr_pc;
    } req_cpu_csr_t;

    typedef struct packed {
        bus64_t csr_rw_rdata;
    } resp_csr_cpu_t;

    typedef struct packed {
        logic      valid;
        bus64_t    pc;
        logic      reg_we;
        reg_addr_t rd;
        bus64_t    data;
    } commit_t;

endpackage
